/* flist.f */
+incdir+common
common/cam_pkg.sv
common/vga_timing_if.sv
capture/ov7670_capture.sv
verilog/frame_buffer.sv
vga/vga_sync.sv
vga/vga_display.sv
verilog/cam_vga_top.sv
testbench/cam_vga_checker.sv
testbench/tb_cam_vga.sv

/* testbench/tb_cam_vga.sv */
// testbench top: clock, reset, lfsr, camera byte stimulus, frame model
// and the test sequence
`timescale 1ns/1ps
`include "cam_cfg.svh"

module tb_cam_vga;

  // one raster frame in clk cycles, two clk per pixel
  localparam int FRAME_CLKS = 2 *
    (`VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK) *
    (`VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK);
  localparam int VSYNC_LIMIT = 2 * FRAME_CLKS;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       capture_en;
  logic       test_mode;
  logic [2:0] rgb_filter;
  logic       cam_pclk;
  logic       cam_vsync;
  logic       cam_href;
  logic [7:0] cam_d;
  logic [3:0] vga_red;
  logic [3:0] vga_green;
  logic [3:0] vga_blue;
  logic       vga_hsync;
  logic       vga_vsync;

  // expected frame buffer contents, red in the top nibble
  logic [`CAM_IMG_PXLS-1:0][11:0] model;
  logic        check_en;
  int          chk_cnt;
  int          err_cnt;
  int          test_cnt = 0;
  logic [31:0] lfsr;
  logic [2:0]  flt_r;
  logic        mode_r;

  always #2 clk = ~clk;

  cam_vga_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .capture_en (capture_en),
    .test_mode  (test_mode),
    .rgb_filter (rgb_filter),
    .cam_pclk   (cam_pclk),
    .cam_vsync  (cam_vsync),
    .cam_href   (cam_href),
    .cam_d      (cam_d),
    .vga_red    (vga_red),
    .vga_green  (vga_green),
    .vga_blue   (vga_blue),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

  cam_vga_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .check_en   (check_en),
    .test_mode  (test_mode),
    .rgb_filter (rgb_filter),
    .model      (model),
    .vga_red    (vga_red),
    .vga_green  (vga_green),
    .vga_blue   (vga_blue),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .chk_cnt    (chk_cnt),
    .err_cnt    (err_cnt)
  );

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  // byte set up while pclk is low, sampled on the rising edge
  task automatic cam_byte(input logic [7:0] b);
    cam_pclk <= 1'b0;
    cam_d    <= b;
    repeat (2) @(negedge clk);
    cam_pclk <= 1'b1;
    repeat (2) @(negedge clk);
  endtask

  // one extra row, two extra pixels and an odd byte per line are all dropped
  task automatic send_frame(input logic en);
    logic [7:0] b0;
    logic [7:0] b1;
    cam_vsync <= 1'b1;
    repeat (8) @(negedge clk);
    cam_vsync <= 1'b0;
    repeat (8) @(negedge clk);
    for (int r = 0; r <= `CAM_IMG_ROWS; r++) begin
      cam_href <= 1'b1;
      for (int c = 0; c < `CAM_IMG_COLS + 2; c++) begin
        b0 = rand_bits(8);
        b1 = rand_bits(8);
        cam_byte(b0);
        cam_byte(b1);
        if (en && r < `CAM_IMG_ROWS && c < `CAM_IMG_COLS)
          model[r * `CAM_IMG_COLS + c] = {b0[3:0], b1};
      end
      cam_byte(rand_bits(8));
      cam_pclk <= 1'b0;
      cam_href <= 1'b0;
      repeat (8) @(negedge clk);
    end
  endtask

  task automatic wait_vsync_fall;
    logic prev;
    logic found;
    int   n;
    prev  = vga_vsync;
    found = 1'b0;
    n     = 0;
    while (!found && n < VSYNC_LIMIT) begin
      @(negedge clk);
      found = prev && !vga_vsync;
      prev  = vga_vsync;
      n++;
    end
    if (!found) begin
      $display("timeout: no falling vga_vsync within %0d clk cycles", VSYNC_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    test_cnt++;
    $display("test %0d %s: %0d checks, %0d errors", test_cnt, name,
             chk_cnt - c0, err_cnt - e0);
  endtask

  // new camera frame, then one whole raster frame is compared
  task automatic run_test(input string name, input logic en, input logic tm,
                          input logic [2:0] flt);
    int c0;
    int e0;
    c0 = chk_cnt;
    e0 = err_cnt;
    capture_en <= en;
    test_mode  <= tm;
    rgb_filter <= flt;
    send_frame(en);
    wait_vsync_fall();
    check_en <= 1'b1;
    wait_vsync_fall();
    check_en <= 1'b0;
    report_test(name, c0, e0);
  endtask

  initial begin
    lfsr       = 32'h4a0b;
    rst_n      = 1'b0;
    capture_en = 1'b0;
    test_mode  = 1'b0;
    rgb_filter = 3'b000;
    cam_pclk   = 1'b0;
    cam_vsync  = 1'b0;
    cam_href   = 1'b0;
    cam_d      = 8'h00;
    check_en   = 1'b0;
    model      = '0;
    repeat (2) @(negedge clk);
    rst_n <= 1'b1;
    repeat (4) @(negedge clk);
    report_test("reset state", 0, 0);
    run_test("captured frame", 1'b1, 1'b0, 3'b111);
    flt_r = 3'(rand_bits(3));
    run_test("random filter", 1'b1, 1'b0, flt_r);
    flt_r = 3'(rand_bits(3));
    run_test("test pattern", 1'b1, 1'b1, flt_r);
    run_test("capture stopped", 1'b0, 1'b0, 3'b111);
    mode_r = rand_bits(1) != 8'h00;
    flt_r  = 3'(rand_bits(3));
    run_test("sync timing, random mode", 1'b1, mode_r, flt_r);
    $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* testbench/cam_vga_checker.sv */
// vga output checker: raster position from the syncs, pixel compare
// against the frame model, sync width and period checks
`timescale 1ns/1ps
`include "cam_cfg.svh"

module cam_vga_checker (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           check_en,
  input  logic                           test_mode,
  input  logic [2:0]                     rgb_filter,
  input  logic [`CAM_IMG_PXLS-1:0][11:0] model,
  input  logic [3:0]                     vga_red,
  input  logic [3:0]                     vga_green,
  input  logic [3:0]                     vga_blue,
  input  logic                           vga_hsync,
  input  logic                           vga_vsync,
  output int                             chk_cnt,
  output int                             err_cnt
);

  localparam int H_TOTAL   = `VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK;
  localparam int V_TOTAL   = `VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK;
  localparam int LINE_CLKS = 2 * H_TOTAL;

  int   cyc = 0;
  // clk count since the last rising hsync
  int   h_cyc = 0;
  // row of the pixels that follow the last rising hsync
  int   row_idx = 0;
  logic row_ok = 1'b0;
  logic hrise_seen = 1'b0;
  logic vrise_seen = 1'b0;
  int   last_hfall = 0;
  int   last_hrise = 0;
  int   last_vfall = 0;
  int   last_vrise = 0;
  logic prev_hs = 1'b1;
  logic prev_vs = 1'b1;
  logic post_rst = 1'b0;

  initial begin
    chk_cnt = 0;
    err_cnt = 0;
  end

  // screen colour from the display rules, filter applied last
  function automatic logic [11:0] expected_pixel(input int col, input int row);
    logic [11:0] p;
    if (row < 0 || row >= `VGA_V_VISIBLE || col >= `VGA_H_VISIBLE)
      p = 12'h000;
    else if (test_mode)
      p = {col[3:0], row[3:0], 4'h0};
    else if (col < `CAM_IMG_COLS && row < `CAM_IMG_ROWS)
      p = model[row * `CAM_IMG_COLS + col];
    else
      p = 12'h000;
    return p & {{4{rgb_filter[2]}}, {4{rgb_filter[1]}}, {4{rgb_filter[0]}}};
  endfunction

  task automatic compare(input string name, input logic [3:0] got,
                         input logic [3:0] exp, input string where);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s at %s: got %h expected %h", name, where, got, exp);
    end
  endtask

  task automatic check_len(input string what, input int got, input int exp);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("%s lasted %0d clk cycles instead of %0d", what, got, exp);
    end
  endtask

  // outputs change on the rising edge, so they are read on the falling one
  always @(negedge clk) begin : watch
    logic [11:0] exp_pxl;
    string       where;
    int          p;
    cyc++;
    if (!rst_n || post_rst) begin
      // idle outputs until the first pixel reaches the pins
      compare("vga_hsync", 4'(vga_hsync), 4'h1, "reset");
      compare("vga_vsync", 4'(vga_vsync), 4'h1, "reset");
      compare("vga_red", vga_red, 4'h0, "reset");
      compare("vga_green", vga_green, 4'h0, "reset");
      compare("vga_blue", vga_blue, 4'h0, "reset");
      post_rst = !rst_n;
    end else begin
      if (!vga_hsync && prev_hs)
        last_hfall = cyc;
      if (vga_hsync && !prev_hs) begin
        if (check_en) begin
          check_len("hsync pulse", cyc - last_hfall, 2 * `VGA_H_SYNC);
          if (hrise_seen)
            check_len("line", cyc - last_hrise, LINE_CLKS);
        end
        last_hrise = cyc;
        hrise_seen = 1'b1;
        h_cyc      = 0;
        row_idx++;
      end else begin
        h_cyc++;
      end
      if (!vga_vsync && prev_vs)
        last_vfall = cyc;
      if (vga_vsync && !prev_vs) begin
        if (check_en) begin
          check_len("vsync pulse", cyc - last_vfall, `VGA_V_SYNC * LINE_CLKS);
          if (vrise_seen)
            check_len("frame", cyc - last_vrise, V_TOTAL * LINE_CLKS);
        end
        last_vrise = cyc;
        vrise_seen = 1'b1;
        // first back porch row
        row_idx    = -`VGA_V_BACK;
        row_ok     = 1'b1;
      end
      // column 0 starts after the back porch, second clk of each pixel
      p = h_cyc - 2 * `VGA_H_BACK;
      if (check_en && row_ok && hrise_seen && p >= 0 && p[0]) begin
        exp_pxl = expected_pixel(p / 2, row_idx);
        where   = $sformatf("col %0d row %0d", p / 2, row_idx);
        compare("vga_red", vga_red, exp_pxl[11:8], where);
        compare("vga_green", vga_green, exp_pxl[7:4], where);
        compare("vga_blue", vga_blue, exp_pxl[3:0], where);
      end
      prev_hs = vga_hsync;
      prev_vs = vga_vsync;
    end
  end

endmodule

/* verilog/cam_vga_top.sv */
// camera to vga top level: capture, frame buffer, raster timing and display
`timescale 1ns/1ps

module cam_vga_top (
  input  logic       clk,
  input  logic       rst_n,
  // low freezes the frame buffer contents
  input  logic       capture_en,
  input  logic       test_mode,
  input  logic [2:0] rgb_filter,
  // camera pins
  input  logic       cam_pclk,
  input  logic       cam_vsync,
  input  logic       cam_href,
  input  logic [7:0] cam_d,
  // vga pins
  output logic [3:0] vga_red,
  output logic [3:0] vga_green,
  output logic [3:0] vga_blue,
  output logic       vga_hsync,
  output logic       vga_vsync
);

  // capture to frame buffer
  logic               cap_wr_en;
  logic               fb_wr_en;
  cam_pkg::pxl_addr_t cap_wr_addr;
  cam_pkg::pixel_t    cap_wr_pixel;

  // frame buffer to display
  cam_pkg::pxl_addr_t disp_rd_addr;
  cam_pkg::pixel_t    disp_rd_pixel;

  vga_timing_if timing_if ();

  ov7670_capture u_capture (
    .clk      (clk),
    .rst_n    (rst_n),
    .pclk     (cam_pclk),
    .vsync    (cam_vsync),
    .href     (cam_href),
    .d        (cam_d),
    .wr_en    (cap_wr_en),
    .wr_addr  (cap_wr_addr),
    .wr_pixel (cap_wr_pixel)
  );

  // stop capture, the screen keeps showing the last frame
  assign fb_wr_en = cap_wr_en & capture_en;

  frame_buffer u_frame_buffer (
    .clk      (clk),
    .wr_en    (fb_wr_en),
    .wr_addr  (cap_wr_addr),
    .wr_pixel (cap_wr_pixel),
    .rd_addr  (disp_rd_addr),
    .rd_pixel (disp_rd_pixel)
  );

  vga_sync u_vga_sync (
    .clk    (clk),
    .rst_n  (rst_n),
    .timing (timing_if.source)
  );

  vga_display u_vga_display (
    .clk        (clk),
    .rst_n      (rst_n),
    .timing     (timing_if.sink),
    .test_mode  (test_mode),
    .rgb_filter (rgb_filter),
    .rd_addr    (disp_rd_addr),
    .rd_pixel   (disp_rd_pixel),
    .vga_red    (vga_red),
    .vga_green  (vga_green),
    .vga_blue   (vga_blue),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

endmodule

/* vga/vga_display.sv */
// frame buffer read, test pattern, colour filter and sync alignment
// in three clk stages from raster position to outputs
`timescale 1ns/1ps
`include "cam_cfg.svh"

module vga_display (
  input  logic                 clk,
  input  logic                 rst_n,
  vga_timing_if.sink           timing,
  input  logic                 test_mode,
  input  cam_pkg::rgb_filter_t rgb_filter,
  output cam_pkg::pxl_addr_t   rd_addr,
  input  cam_pkg::pixel_t      rd_pixel,
  output logic [3:0]           vga_red,
  output logic [3:0]           vga_green,
  output logic [3:0]           vga_blue,
  output logic                 vga_hsync,
  output logic                 vga_vsync
);

  // raster position falls inside the captured image
  logic            in_img0;

  // stage one holds the address sent to the memory
  logic            in_img1;
  logic            vis1;
  logic            hs1;
  logic            vs1;
  logic [3:0]      tst_red1;
  logic [3:0]      tst_green1;

  // stage two waits for the memory read
  logic            in_img2;
  logic            vis2;
  logic            hs2;
  logic            vs2;
  logic [3:0]      tst_red2;
  logic [3:0]      tst_green2;

  // colour before and after the filter
  cam_pkg::pixel_t sel_pxl;
  cam_pkg::pixel_t flt_pxl;

  assign in_img0 = (timing.col < cam_pkg::coord_t'(`CAM_IMG_COLS)) &&
                   (timing.row < cam_pkg::coord_t'(`CAM_IMG_ROWS));

  // flags and syncs through stages one and two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_img1 <= 1'b0;
      vis1    <= 1'b0;
      hs1     <= 1'b1;
      vs1     <= 1'b1;
      in_img2 <= 1'b0;
      vis2    <= 1'b0;
      hs2     <= 1'b1;
      vs2     <= 1'b1;
    end else begin
      in_img1 <= in_img0;
      vis1    <= timing.visible;
      hs1     <= timing.hsync;
      vs1     <= timing.vsync;
      in_img2 <= in_img1;
      vis2    <= vis1;
      hs2     <= hs1;
      vs2     <= vs1;
    end
  end

  // read address and pattern nibbles, taken once per pixel on its first clk
  // the address wraps outside the image and in_img masks the result there
  always_ff @(posedge clk) begin
    if (!timing.new_pxl) begin
      rd_addr    <= cam_pkg::pxl_addr_t'(timing.row * `CAM_IMG_COLS + timing.col);
      tst_red1   <= timing.col[3:0];
      tst_green1 <= timing.row[3:0];
    end
    tst_red2   <= tst_red1;
    tst_green2 <= tst_green1;
  end

  always_comb begin
    // test pattern, then image pixel, then black
    if (test_mode) begin
      sel_pxl.red   = tst_red2;
      sel_pxl.green = tst_green2;
      sel_pxl.blue  = 4'h0;
    end else if (in_img2) begin
      sel_pxl = rd_pixel;
    end else begin
      sel_pxl = '0;
    end
    // channel mask and blanking outside the visible area
    flt_pxl.red   = (rgb_filter[2] && vis2) ? sel_pxl.red   : 4'h0;
    flt_pxl.green = (rgb_filter[1] && vis2) ? sel_pxl.green : 4'h0;
    flt_pxl.blue  = (rgb_filter[0] && vis2) ? sel_pxl.blue  : 4'h0;
  end

  // stage three registers all outputs on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vga_red   <= 4'h0;
      vga_green <= 4'h0;
      vga_blue  <= 4'h0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      vga_red   <= flt_pxl.red;
      vga_green <= flt_pxl.green;
      vga_blue  <= flt_pxl.blue;
      vga_hsync <= hs2;
      vga_vsync <= vs2;
    end
  end

endmodule

/* vga/vga_sync.sv */
// raster timing generator: pixel-enable divider, column and row counters,
// visible flag and active low syncs
`timescale 1ns/1ps
`include "cam_cfg.svh"

module vga_sync (
  input  logic         clk,
  input  logic         rst_n,
  vga_timing_if.source timing
);

  // line and frame totals
  localparam int H_TOTAL = `VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK;
  localparam int V_TOTAL = `VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK;
  // sync intervals, end is exclusive
  localparam int H_SYNC_START = `VGA_H_VISIBLE + `VGA_H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + `VGA_H_SYNC;
  localparam int V_SYNC_START = `VGA_V_VISIBLE + `VGA_V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + `VGA_V_SYNC;

  logic            pxl_toggle;
  cam_pkg::coord_t col;
  cam_pkg::coord_t row;

  // clk / 2 pixel enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      pxl_toggle <= 1'b0;
    else
      pxl_toggle <= ~pxl_toggle;
  end

  // counters step on the strobe, row steps at the end of each line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col <= '0;
      row <= '0;
    end else if (pxl_toggle) begin
      if (col == cam_pkg::coord_t'(H_TOTAL - 1)) begin
        col <= '0;
        if (row == cam_pkg::coord_t'(V_TOTAL - 1))
          row <= '0;
        else
          row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  assign timing.new_pxl = pxl_toggle;
  assign timing.col     = col;
  assign timing.row     = row;

  // decoded straight from the counters so they move with col and row
  assign timing.visible = (col < cam_pkg::coord_t'(`VGA_H_VISIBLE)) &&
                          (row < cam_pkg::coord_t'(`VGA_V_VISIBLE));
  // low during the sync interval
  assign timing.hsync   = !((col >= cam_pkg::coord_t'(H_SYNC_START)) &&
                            (col <  cam_pkg::coord_t'(H_SYNC_END)));
  assign timing.vsync   = !((row >= cam_pkg::coord_t'(V_SYNC_START)) &&
                            (row <  cam_pkg::coord_t'(V_SYNC_END)));

endmodule

/* verilog/frame_buffer.sv */
// simple dual-port pixel memory, one write port and one registered read port
`timescale 1ns/1ps
`include "cam_cfg.svh"

module frame_buffer (
  input  logic               clk,
  // capture side
  input  logic               wr_en,
  input  cam_pkg::pxl_addr_t wr_addr,
  input  cam_pkg::pixel_t    wr_pixel,
  // display side
  input  cam_pkg::pxl_addr_t rd_addr,
  output cam_pkg::pixel_t    rd_pixel
);

  // one word per image pixel
  cam_pkg::pixel_t mem [`CAM_IMG_PXLS];

  // write on the pulse
  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_pixel;
  end

  // read data arrives one cycle after the address
  // a collision with a write gives the old word
  always_ff @(posedge clk) begin
    rd_pixel <= mem[rd_addr];
  end

endmodule

/* capture/ov7670_capture.sv */
// ov7670 rgb444 capture: pin synchroniser, byte pairing and frame buffer
// write addressing
`timescale 1ns/1ps
`include "cam_cfg.svh"

module ov7670_capture (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pclk,
  input  logic               vsync,
  input  logic               href,
  input  logic [7:0]         d,
  output logic               wr_en,
  output cam_pkg::pxl_addr_t wr_addr,
  output cam_pkg::pixel_t    wr_pixel
);

  // counters saturate one past the image, so they need room for that value
  localparam int NB_COL = $clog2(`CAM_IMG_COLS + 1);
  localparam int NB_ROW = $clog2(`CAM_IMG_ROWS + 1);

  // two sync stages plus one more for edge detection
  logic [2:0]        pclk_sr;
  logic [2:0]        vsync_sr;
  logic [2:0]        href_sr;
  logic [7:0]        d_s1;
  logic [7:0]        d_s2;

  logic              pclk_rise;
  logic              vsync_rise;
  logic              href_fall;
  logic              sample;

  // 0: waiting for the first byte of a pixel, 1: waiting for the second
  logic              byte_phase;
  logic [3:0]        red_hold;
  logic [NB_COL-1:0] col_cnt;
  logic [NB_ROW-1:0] row_cnt;
  logic              in_img;

  // control pins, bit 1 is the synchronised level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pclk_sr  <= '0;
      vsync_sr <= '0;
      href_sr  <= '0;
    end else begin
      pclk_sr  <= {pclk_sr[1:0], pclk};
      vsync_sr <= {vsync_sr[1:0], vsync};
      href_sr  <= {href_sr[1:0], href};
    end
  end

  // data bus, same two-stage delay as the strobes
  always_ff @(posedge clk) begin
    d_s1 <= d;
    d_s2 <= d_s1;
  end

  assign pclk_rise  = pclk_sr[1] & ~pclk_sr[2];
  assign vsync_rise = vsync_sr[1] & ~vsync_sr[2];
  assign href_fall  = ~href_sr[1] & href_sr[2];
  // byte strobe, only bytes inside href count
  assign sample     = pclk_rise & href_sr[1];

  // bytes past the image edge are dropped here
  assign in_img = (col_cnt < NB_COL'(`CAM_IMG_COLS)) &&
                  (row_cnt < NB_ROW'(`CAM_IMG_ROWS));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_phase <= 1'b0;
      col_cnt    <= '0;
      row_cnt    <= '0;
      wr_en      <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (vsync_rise) begin
        // new frame starts at the top left
        byte_phase <= 1'b0;
        col_cnt    <= '0;
        row_cnt    <= '0;
      end else if (href_fall) begin
        // end of line, an unpaired byte is lost
        byte_phase <= 1'b0;
        col_cnt    <= '0;
        if (row_cnt < NB_ROW'(`CAM_IMG_ROWS))
          row_cnt <= row_cnt + 1'b1;
      end else if (sample) begin
        byte_phase <= ~byte_phase;
        if (byte_phase) begin
          wr_en <= in_img;
          if (col_cnt < NB_COL'(`CAM_IMG_COLS))
            col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

  // pixel payload
  // first byte xxxxRRRR, second byte GGGGBBBB
  always_ff @(posedge clk) begin
    if (sample && !byte_phase)
      red_hold <= d_s2[3:0];
    if (sample && byte_phase) begin
      wr_pixel <= {red_hold, d_s2[7:4], d_s2[3:0]};
      wr_addr  <= cam_pkg::pxl_addr_t'(row_cnt * `CAM_IMG_COLS + col_cnt);
    end
  end

endmodule

/* common/vga_timing_if.sv */
// raster timing bundle between the sync generator and the display block
`timescale 1ns/1ps

interface vga_timing_if;

  // one-cycle strobe every second clk
  logic            new_pxl;
  // high inside the visible area
  logic            visible;
  // active low syncs
  logic            hsync;
  logic            vsync;
  // raster position, steps in the cycle after new_pxl
  cam_pkg::coord_t col;
  cam_pkg::coord_t row;

  // generator side
  modport source (
    output new_pxl,
    output visible,
    output hsync,
    output vsync,
    output col,
    output row
  );

  // display side
  modport sink (
    input new_pxl,
    input visible,
    input hsync,
    input vsync,
    input col,
    input row
  );

endinterface

/* common/cam_pkg.sv */
// pixel, frame buffer address, raster coordinate and colour filter types
`include "cam_cfg.svh"

package cam_pkg;

  // rgb444 pixel as stored in the frame buffer
  // red sits in the top nibble, blue in the bottom one
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_t;

  // linear frame buffer address, row * image columns + column
  typedef logic [`CAM_NB_ADDR-1:0] pxl_addr_t;

  // raster column or row
  typedef logic [`VGA_NB_COORD-1:0] coord_t;

  // per-channel keep mask
  // bit 2 red, bit 1 green, bit 0 blue
  // a cleared bit blanks that channel
  typedef logic [2:0] rgb_filter_t;

endpackage

/* common/cam_cfg.svh */
// image size, frame buffer address width and raster timing macros
`ifndef CAM_CFG_SVH
`define CAM_CFG_SVH

// captured image, kept small so a simulation covers whole frames
`define CAM_IMG_COLS 8
`define CAM_IMG_ROWS 4
`define CAM_IMG_PXLS 32
// log2 of CAM_IMG_PXLS
`define CAM_NB_ADDR 5

// horizontal raster, in pixels
`define VGA_H_VISIBLE 16
`define VGA_H_FRONT 2
`define VGA_H_SYNC 2
`define VGA_H_BACK 2

// vertical raster, in lines
`define VGA_V_VISIBLE 8
`define VGA_V_FRONT 1
`define VGA_V_SYNC 1
`define VGA_V_BACK 1

// column and row counters must hold the line total (22)
`define VGA_NB_COORD 5

`endif
